// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FLIST     ?= id_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== id_stage.f ====
+incdir+include
source/id_pkg.sv
source/id_decoder.sv
source/id_operand_fetch.sv
source/id_branch_unit.sv
source/id_ex_register.sv
source/id_stage_top.sv
sim/id_stage_tb.sv

// ==== include/id_defs.svh ====
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath widths
`define ID_WORD_W      32
`define ID_REG_ADDR_W  5

// JAL writes the return address here
`define ID_LINK_REG    31

////////////////////////////////
// primary opcodes in inst[31:26]
////////////////////////////////
`define ID_OP_SPECIAL  6'b000000
`define ID_OP_ORI      6'b001101
`define ID_OP_ANDI     6'b001100
`define ID_OP_XORI     6'b001110
`define ID_OP_LUI      6'b001111
`define ID_OP_ADDIU    6'b001001
`define ID_OP_SLTI     6'b001010
`define ID_OP_SLTIU    6'b001011
`define ID_OP_LW       6'b100011
`define ID_OP_LB       6'b100000
`define ID_OP_SW       6'b101011
`define ID_OP_BEQ      6'b000100
`define ID_OP_BNE      6'b000101
`define ID_OP_BGTZ     6'b000111
`define ID_OP_BLEZ     6'b000110
`define ID_OP_J        6'b000010
`define ID_OP_JAL      6'b000011

////////////////////////////////
// SPECIAL function codes in inst[5:0]
////////////////////////////////
`define ID_FN_SLL      6'b000000
`define ID_FN_SRL      6'b000010
`define ID_FN_SRA      6'b000011
`define ID_FN_SLLV     6'b000100
`define ID_FN_SRLV     6'b000110
`define ID_FN_SRAV     6'b000111
`define ID_FN_JR       6'b001000
`define ID_FN_JALR     6'b001001
`define ID_FN_ADDU     6'b100001
`define ID_FN_SUBU     6'b100011
`define ID_FN_AND      6'b100100
`define ID_FN_OR       6'b100101
`define ID_FN_XOR      6'b100110
`define ID_FN_NOR      6'b100111
`define ID_FN_SLT      6'b101010
`define ID_FN_SLTU     6'b101011

`endif

// ==== sim/id_stage_tb.sv ====
`default_nettype none

`include "id_defs.svh"

module id_stage_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_INST     = 400;
	localparam int DRIVE_DELAY  = 2;
	localparam int SETTLE_DELAY = 10;
	localparam int WATCHDOG     = (NUM_INST + RESET_CYCLES) * 4 * CLK_PERIOD;

	logic               clk;
	logic               rst_i;
	id_pkg::inst_addr_t pc_i;
	id_pkg::inst_t      inst_i;
	id_pkg::word_t      reg1_data_i;
	id_pkg::word_t      reg2_data_i;
	id_pkg::fwd_t       ex_fwd_i;
	id_pkg::fwd_t       mem_fwd_i;
	id_pkg::rf_read_t   rd1_o;
	id_pkg::rf_read_t   rd2_o;
	id_pkg::branch_t    branch_o;
	id_pkg::id_ex_t     ex_o;
	logic               stall_o;

	logic [31:0] lfsr;
	int          read_errors;
	int          branch_errors;
	int          stall_errors;
	int          ex_errors;
	int          other_errors;
	int          stall_count;

	id_stage_top id_stage_top_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.rd1_o       (rd1_o),
		.rd2_o       (rd2_o),
		.branch_o    (branch_o),
		.ex_o        (ex_o),
		.stall_o     (stall_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG);
		$display("timeout: the run did not finish in %0d time units", WATCHDOG);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//////////////////////////////
	// random source
	//////////////////////////////

	// galois lfsr stepped once per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic id_pkg::inst_t build_inst();
		int            kind;
		logic [5:0]    code;
		logic [4:0]    rs;
		logic [4:0]    rt;
		logic [4:0]    rd;
		logic [4:0]    sa;
		logic [15:0]   imm;
		logic [25:0]   idx;
		id_pkg::inst_t w;
		kind = int'(next_bits(6)) % 36;
		// few registers so bypass hits are common
		rs = 5'(next_bits(2));
		rt = 5'(next_bits(2));
		rd = 5'(next_bits(2));
		sa = 5'(next_bits(5));
		imm = 16'(next_bits(16));
		idx = 26'(next_bits(26));
		case (kind)
			0:  code = `ID_FN_OR;
			1:  code = `ID_FN_AND;
			2:  code = `ID_FN_XOR;
			3:  code = `ID_FN_NOR;
			4:  code = `ID_FN_SLLV;
			5:  code = `ID_FN_SRLV;
			6:  code = `ID_FN_SRAV;
			7:  code = `ID_FN_ADDU;
			8:  code = `ID_FN_SUBU;
			9:  code = `ID_FN_SLT;
			10: code = `ID_FN_SLTU;
			11: code = `ID_FN_JR;
			12: code = `ID_FN_JALR;
			13: code = `ID_FN_SLL;
			14: code = `ID_FN_SRL;
			15: code = `ID_FN_SRA;
			16: code = `ID_OP_ORI;
			17: code = `ID_OP_ANDI;
			18: code = `ID_OP_XORI;
			19: code = `ID_OP_LUI;
			20: code = `ID_OP_ADDIU;
			21: code = `ID_OP_SLTI;
			22: code = `ID_OP_SLTIU;
			23: code = `ID_OP_LW;
			24: code = `ID_OP_LB;
			25: code = `ID_OP_SW;
			26: code = `ID_OP_BEQ;
			27: code = `ID_OP_BNE;
			28: code = `ID_OP_BGTZ;
			29: code = `ID_OP_BLEZ;
			30: code = `ID_OP_J;
			31: code = `ID_OP_JAL;
			default: code = 6'd0;
		endcase
		if (kind < 13) begin
			w = {`ID_OP_SPECIAL, rs, rt, rd, 5'd0, code};
		end else if (kind < 16) begin
			w = {`ID_OP_SPECIAL, 5'd0, rt, rd, sa, code};
		end else if (kind < 30) begin
			w = {code, rs, rt, imm};
		end else if (kind < 32) begin
			w = {code, idx};
		end else begin
			w = next_bits(32);
		end
		return w;
	endfunction

	function automatic id_pkg::fwd_t draw_fwd();
		id_pkg::fwd_t f;
		logic [1:0]   pick;
		f.wreg = 1'(next_bits(1));
		f.wd = 5'(next_bits(2));
		f.wdata = next_bits(32);
		pick = 2'(next_bits(2));
		// loads in EX often enough to hit the hazard
		if (pick == 2'd0) begin
			f.aluop = id_pkg::ALU_LW;
		end else if (pick == 2'd1) begin
			f.aluop = id_pkg::ALU_LB;
		end else begin
			f.aluop = id_pkg::aluop_t'(5'(next_bits(5)));
		end
		return f;
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic id_pkg::alusel_t class_of(input id_pkg::aluop_t op);
		case (op)
			id_pkg::ALU_NOP: return id_pkg::SEL_NOP;
			id_pkg::ALU_OR, id_pkg::ALU_AND, id_pkg::ALU_XOR, id_pkg::ALU_NOR:
				return id_pkg::SEL_LOGIC;
			id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA: return id_pkg::SEL_SHIFT;
			id_pkg::ALU_ADDU, id_pkg::ALU_SUBU, id_pkg::ALU_SLT, id_pkg::ALU_SLTU:
				return id_pkg::SEL_ARITH;
			id_pkg::ALU_LW, id_pkg::ALU_LB, id_pkg::ALU_SW: return id_pkg::SEL_LOAD_STORE;
			default: return id_pkg::SEL_JUMP_BRANCH;
		endcase
	endfunction

	function automatic id_pkg::dec_t model_decode(input id_pkg::inst_t w);
		id_pkg::dec_t d;
		logic [5:0]   op;
		logic [5:0]   fn;
		op = w[31:26];
		fn = w[5:0];
		d = '0;
		d.rd1.addr = w[25:21];
		d.rd2.addr = w[20:16];
		d.wd = w[15:11];
		if (op == `ID_OP_SPECIAL) begin
			if (fn == `ID_FN_SLL || fn == `ID_FN_SRL || fn == `ID_FN_SRA) begin
				if (w[25:21] == 5'd0) begin
					case (fn)
						`ID_FN_SLL: d.aluop = id_pkg::ALU_SLL;
						`ID_FN_SRL: d.aluop = id_pkg::ALU_SRL;
						default:    d.aluop = id_pkg::ALU_SRA;
					endcase
					d.rd2.re = 1'b1;
					d.wreg = 1'b1;
					d.imm = {27'd0, w[10:6]};
				end
			end else if (w[10:6] == 5'd0) begin
				case (fn)
					`ID_FN_OR:   d.aluop = id_pkg::ALU_OR;
					`ID_FN_AND:  d.aluop = id_pkg::ALU_AND;
					`ID_FN_XOR:  d.aluop = id_pkg::ALU_XOR;
					`ID_FN_NOR:  d.aluop = id_pkg::ALU_NOR;
					`ID_FN_SLLV: d.aluop = id_pkg::ALU_SLL;
					`ID_FN_SRLV: d.aluop = id_pkg::ALU_SRL;
					`ID_FN_SRAV: d.aluop = id_pkg::ALU_SRA;
					`ID_FN_ADDU: d.aluop = id_pkg::ALU_ADDU;
					`ID_FN_SUBU: d.aluop = id_pkg::ALU_SUBU;
					`ID_FN_SLT:  d.aluop = id_pkg::ALU_SLT;
					`ID_FN_SLTU: d.aluop = id_pkg::ALU_SLTU;
					`ID_FN_JR:   d.aluop = id_pkg::ALU_JR;
					`ID_FN_JALR: d.aluop = id_pkg::ALU_JALR;
					default:     d.aluop = id_pkg::ALU_NOP;
				endcase
				if (d.aluop != id_pkg::ALU_NOP) begin
					d.rd1.re = 1'b1;
					d.rd2.re = (d.aluop != id_pkg::ALU_JR) && (d.aluop != id_pkg::ALU_JALR);
					d.wreg = (d.aluop != id_pkg::ALU_JR);
					d.link_en = (d.aluop == id_pkg::ALU_JALR);
				end
			end
		end else begin
			case (op)
				`ID_OP_ORI, `ID_OP_LUI: d.aluop = id_pkg::ALU_OR;
				`ID_OP_ANDI:  d.aluop = id_pkg::ALU_AND;
				`ID_OP_XORI:  d.aluop = id_pkg::ALU_XOR;
				`ID_OP_ADDIU: d.aluop = id_pkg::ALU_ADDU;
				`ID_OP_SLTI:  d.aluop = id_pkg::ALU_SLT;
				`ID_OP_SLTIU: d.aluop = id_pkg::ALU_SLTU;
				`ID_OP_LW:    d.aluop = id_pkg::ALU_LW;
				`ID_OP_LB:    d.aluop = id_pkg::ALU_LB;
				`ID_OP_SW:    d.aluop = id_pkg::ALU_SW;
				`ID_OP_BEQ:   d.aluop = id_pkg::ALU_BEQ;
				`ID_OP_BNE:   d.aluop = id_pkg::ALU_BNE;
				`ID_OP_BGTZ:  d.aluop = id_pkg::ALU_BGTZ;
				`ID_OP_BLEZ:  d.aluop = id_pkg::ALU_BLEZ;
				`ID_OP_J:     d.aluop = id_pkg::ALU_J;
				`ID_OP_JAL:   d.aluop = id_pkg::ALU_JAL;
				default:      d.aluop = id_pkg::ALU_NOP;
			endcase
			case (op)
				`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI: d.imm = {16'h0, w[15:0]};
				`ID_OP_LUI: d.imm = {w[15:0], 16'h0};
				`ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU, `ID_OP_LW, `ID_OP_LB:
					d.imm = {{16{w[15]}}, w[15:0]};
				default: d.imm = '0;
			endcase
			// I-type results go to rt
			case (d.aluop)
				id_pkg::ALU_OR, id_pkg::ALU_AND, id_pkg::ALU_XOR, id_pkg::ALU_ADDU,
				id_pkg::ALU_SLT, id_pkg::ALU_SLTU, id_pkg::ALU_LW, id_pkg::ALU_LB: begin
					d.rd1.re = 1'b1;
					d.wreg = 1'b1;
					d.wd = w[20:16];
				end
				id_pkg::ALU_SW: begin
					d.rd1.re = 1'b1;
					d.rd2.re = 1'b1;
					d.wd = w[20:16];
				end
				id_pkg::ALU_BEQ, id_pkg::ALU_BNE: begin
					d.rd1.re = 1'b1;
					d.rd2.re = 1'b1;
				end
				id_pkg::ALU_BGTZ, id_pkg::ALU_BLEZ: d.rd1.re = 1'b1;
				id_pkg::ALU_JAL: begin
					d.wreg = 1'b1;
					d.wd = id_pkg::reg_addr_t'(`ID_LINK_REG);
					d.link_en = 1'b1;
				end
				default: begin
				end
			endcase
		end
		d.alusel = class_of(d.aluop);
		return d;
	endfunction

	function automatic id_pkg::word_t model_operand(input id_pkg::rf_read_t rd,
			input id_pkg::word_t rf, input id_pkg::word_t imm);
		if (!rd.re) begin
			return imm;
		end
		if (ex_fwd_i.wreg && ex_fwd_i.wd == rd.addr) begin
			return ex_fwd_i.wdata;
		end
		if (mem_fwd_i.wreg && mem_fwd_i.wd == rd.addr) begin
			return mem_fwd_i.wdata;
		end
		return rf;
	endfunction

	function automatic id_pkg::branch_t model_branch(input id_pkg::inst_addr_t pc,
			input id_pkg::inst_t w, input id_pkg::aluop_t op,
			input id_pkg::word_t r1, input id_pkg::word_t r2);
		id_pkg::branch_t    b;
		id_pkg::inst_addr_t next_pc;
		next_pc = pc + 32'd4;
		b = '0;
		case (op)
			id_pkg::ALU_BEQ:  b.taken = (r1 == r2);
			id_pkg::ALU_BNE:  b.taken = (r1 != r2);
			id_pkg::ALU_BGTZ: b.taken = ($signed(r1) > 0);
			id_pkg::ALU_BLEZ: b.taken = ($signed(r1) <= 0);
			id_pkg::ALU_J, id_pkg::ALU_JAL, id_pkg::ALU_JR, id_pkg::ALU_JALR: b.taken = 1'b1;
			default: b.taken = 1'b0;
		endcase
		if (op == id_pkg::ALU_J || op == id_pkg::ALU_JAL) begin
			b.target = {next_pc[31:28], w[25:0], 2'b00};
		end else if (op == id_pkg::ALU_JR || op == id_pkg::ALU_JALR) begin
			b.target = r1;
		end else if (b.taken) begin
			b.target = next_pc + {{14{w[15]}}, w[15:0], 2'b00};
		end
		return b;
	endfunction

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_read(input string name, input id_pkg::rf_read_t got,
			input id_pkg::rf_read_t exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			read_errors++;
		end
	endtask

	task automatic check_branch(input id_pkg::branch_t got, input id_pkg::branch_t exp);
		if (got !== exp) begin
			$display("error: branch_o got %h expected %h", got, exp);
			branch_errors++;
		end
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: stall_o got %h expected %h", got, exp);
			stall_errors++;
		end
	endtask

	task automatic check_ex(input id_pkg::id_ex_t got, input id_pkg::id_ex_t exp);
		if (got !== exp) begin
			$display("error: ex_o got %h expected %h", got, exp);
			ex_errors++;
		end
	endtask

	//////////////////////////////
	// stimulus and checking
	//////////////////////////////

	initial begin
		int              cyc;
		int              n_done;
		int              total;
		logic            hold;
		logic            have_exp;
		logic            exp_stall;
		id_pkg::dec_t    d;
		id_pkg::word_t   r1;
		id_pkg::word_t   r2;
		id_pkg::branch_t exp_br;
		id_pkg::id_ex_t  exp_ex;

		rst_i = 1'b1;
		pc_i = '0;
		inst_i = '0;
		reg1_data_i = '0;
		reg2_data_i = '0;
		ex_fwd_i = '0;
		mem_fwd_i = '0;
		lfsr = 32'hd93f_ff34;
		read_errors = 0;
		branch_errors = 0;
		stall_errors = 0;
		ex_errors = 0;
		other_errors = 0;
		stall_count = 0;
		cyc = 0;
		n_done = 0;
		hold = 1'b0;
		have_exp = 1'b0;
		exp_ex = '0;

		while (n_done < NUM_INST) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			if (have_exp) begin
				check_ex(ex_o, exp_ex);
			end
			rst_i = (cyc < RESET_CYCLES);
			// a stalled instruction is presented again
			if (!hold) begin
				pc_i = {30'(next_bits(30)), 2'b00};
				inst_i = build_inst();
			end
			reg1_data_i = next_bits(32);
			reg2_data_i = next_bits(32);
			if (3'(next_bits(3)) == 3'd0) begin
				reg1_data_i = '0;
			end
			if (1'(next_bits(1))) begin
				reg2_data_i = reg1_data_i;
			end
			ex_fwd_i = draw_fwd();
			mem_fwd_i = draw_fwd();
			#(SETTLE_DELAY);

			d = rst_i ? id_pkg::dec_t'('0) : model_decode(inst_i);
			r1 = rst_i ? id_pkg::word_t'('0) : model_operand(d.rd1, reg1_data_i, d.imm);
			r2 = rst_i ? id_pkg::word_t'('0) : model_operand(d.rd2, reg2_data_i, d.imm);
			exp_stall = !rst_i &&
					(ex_fwd_i.aluop == id_pkg::ALU_LW || ex_fwd_i.aluop == id_pkg::ALU_LB) &&
					((d.rd1.re && ex_fwd_i.wd == d.rd1.addr) ||
					(d.rd2.re && ex_fwd_i.wd == d.rd2.addr));
			exp_br = model_branch(pc_i, inst_i, d.aluop, r1, r2);

			check_read("rd1_o", rd1_o, d.rd1);
			check_read("rd2_o", rd2_o, d.rd2);
			check_branch(branch_o, exp_br);
			check_stall(stall_o, exp_stall);

			// bubble on reset or stall
			exp_ex = '0;
			if (!rst_i && !exp_stall) begin
				exp_ex.aluop = d.aluop;
				exp_ex.alusel = d.alusel;
				exp_ex.reg1 = r1;
				exp_ex.reg2 = r2;
				exp_ex.wd = d.wd;
				exp_ex.wreg = d.wreg;
				exp_ex.link_addr = d.link_en ? pc_i + 32'd8 : '0;
			end
			have_exp = 1'b1;
			hold = exp_stall;
			if (exp_stall) begin
				stall_count++;
			end
			if (!rst_i && !exp_stall) begin
				n_done++;
			end
			cyc++;
		end

		@(posedge clk);
		#(DRIVE_DELAY);
		check_ex(ex_o, exp_ex);

		if (stall_count == 0) begin
			$display("the run never raised a load-use stall");
			other_errors++;
		end
		total = read_errors + branch_errors + stall_errors + ex_errors + other_errors;
		$display("errors: %0d (read %0d, branch %0d, stall %0d, ex %0d, other %0d)",
				total, read_errors, branch_errors, stall_errors, ex_errors, other_errors);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/id_branch_unit.sv ====
`default_nettype none

module id_branch_unit (
	input  id_pkg::inst_addr_t pc_i,
	input  id_pkg::inst_t      inst_i,
	input  id_pkg::dec_t       dec_i,
	input  id_pkg::word_t      reg1_i,
	input  id_pkg::word_t      reg2_i,
	output id_pkg::branch_t    branch_o,
	output id_pkg::word_t      link_addr_o
);

	id_pkg::inst_addr_t pc_plus_4;
	id_pkg::inst_addr_t pc_plus_8;
	id_pkg::word_t      br_offset;
	id_pkg::inst_addr_t br_target;
	id_pkg::inst_addr_t jump_target;
	logic               cond;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;

	// sign-extended word offset
	assign br_offset   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign br_target   = pc_plus_4 + br_offset;
	assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

	always_comb begin
		case (dec_i.aluop)
			id_pkg::ALU_BEQ:  cond = (reg1_i == reg2_i);
			id_pkg::ALU_BNE:  cond = (reg1_i != reg2_i);
			id_pkg::ALU_BGTZ: cond = !reg1_i[31] && (reg1_i != '0);
			id_pkg::ALU_BLEZ: cond = reg1_i[31] || (reg1_i == '0);
			default:          cond = 1'b0;
		endcase
	end

	always_comb begin
		branch_o = '0;
		case (dec_i.aluop)
			id_pkg::ALU_BEQ, id_pkg::ALU_BNE, id_pkg::ALU_BGTZ, id_pkg::ALU_BLEZ: begin
				branch_o.taken = cond;
				branch_o.target = cond ? br_target : '0;
			end
			id_pkg::ALU_J, id_pkg::ALU_JAL: begin
				branch_o.taken = 1'b1;
				branch_o.target = jump_target;
			end
			// register jumps use the bypassed operand
			id_pkg::ALU_JR, id_pkg::ALU_JALR: begin
				branch_o.taken = 1'b1;
				branch_o.target = reg1_i;
			end
			default: begin
			end
		endcase
	end

	assign link_addr_o = dec_i.link_en ? pc_plus_8 : '0;

endmodule

`default_nettype wire

// ==== source/id_decoder.sv ====
`default_nettype none

`include "id_defs.svh"

module id_decoder (
	input  logic          rst_i,
	input  id_pkg::inst_t inst_i,
	output id_pkg::dec_t  dec_o
);

	// instruction fields
	logic [5:0]        op;
	logic [5:0]        funct;
	logic [4:0]        sa;
	id_pkg::reg_addr_t rs;
	id_pkg::reg_addr_t rt;
	id_pkg::reg_addr_t rd;
	logic [15:0]       imm16;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign sa    = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	always_comb begin
		dec_o = '0;
		dec_o.aluop = id_pkg::ALU_NOP;
		dec_o.alusel = id_pkg::SEL_NOP;
		if (!rst_i) begin
			dec_o.rd1.addr = rs;
			dec_o.rd2.addr = rt;
			dec_o.wd = rd;
			case (op)
				`ID_OP_SPECIAL: begin
					case (funct)
						// immediate shifts need rs zero and read rt on port 2
						`ID_FN_SLL, `ID_FN_SRL, `ID_FN_SRA: begin
							if (rs == '0) begin
								dec_o.wreg = 1'b1;
								dec_o.rd2.re = 1'b1;
								dec_o.alusel = id_pkg::SEL_SHIFT;
								dec_o.imm = {{(`ID_WORD_W-5){1'b0}}, sa};
								if (funct == `ID_FN_SLL) begin
									dec_o.aluop = id_pkg::ALU_SLL;
								end else if (funct == `ID_FN_SRL) begin
									dec_o.aluop = id_pkg::ALU_SRL;
								end else begin
									dec_o.aluop = id_pkg::ALU_SRA;
								end
							end
						end
						default: begin
							if (sa == 5'd0) begin
								dec_o.wreg = 1'b1;
								dec_o.rd1.re = 1'b1;
								dec_o.rd2.re = 1'b1;
								case (funct)
									`ID_FN_OR: begin
										dec_o.aluop = id_pkg::ALU_OR;
										dec_o.alusel = id_pkg::SEL_LOGIC;
									end
									`ID_FN_AND: begin
										dec_o.aluop = id_pkg::ALU_AND;
										dec_o.alusel = id_pkg::SEL_LOGIC;
									end
									`ID_FN_XOR: begin
										dec_o.aluop = id_pkg::ALU_XOR;
										dec_o.alusel = id_pkg::SEL_LOGIC;
									end
									`ID_FN_NOR: begin
										dec_o.aluop = id_pkg::ALU_NOR;
										dec_o.alusel = id_pkg::SEL_LOGIC;
									end
									`ID_FN_SLLV: begin
										dec_o.aluop = id_pkg::ALU_SLL;
										dec_o.alusel = id_pkg::SEL_SHIFT;
									end
									`ID_FN_SRLV: begin
										dec_o.aluop = id_pkg::ALU_SRL;
										dec_o.alusel = id_pkg::SEL_SHIFT;
									end
									`ID_FN_SRAV: begin
										dec_o.aluop = id_pkg::ALU_SRA;
										dec_o.alusel = id_pkg::SEL_SHIFT;
									end
									`ID_FN_ADDU: begin
										dec_o.aluop = id_pkg::ALU_ADDU;
										dec_o.alusel = id_pkg::SEL_ARITH;
									end
									`ID_FN_SUBU: begin
										dec_o.aluop = id_pkg::ALU_SUBU;
										dec_o.alusel = id_pkg::SEL_ARITH;
									end
									`ID_FN_SLT: begin
										dec_o.aluop = id_pkg::ALU_SLT;
										dec_o.alusel = id_pkg::SEL_ARITH;
									end
									`ID_FN_SLTU: begin
										dec_o.aluop = id_pkg::ALU_SLTU;
										dec_o.alusel = id_pkg::SEL_ARITH;
									end
									`ID_FN_JR: begin
										dec_o.aluop = id_pkg::ALU_JR;
										dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
										dec_o.wreg = 1'b0;
										dec_o.rd2.re = 1'b0;
									end
									`ID_FN_JALR: begin
										dec_o.aluop = id_pkg::ALU_JALR;
										dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
										dec_o.rd2.re = 1'b0;
										dec_o.link_en = 1'b1;
									end
									default: begin
										// unknown function decodes as NOP
										dec_o.wreg = 1'b0;
										dec_o.rd1.re = 1'b0;
										dec_o.rd2.re = 1'b0;
									end
								endcase
							end
						end
					endcase
				end
				`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI, `ID_OP_LUI: begin
					dec_o.wreg = 1'b1;
					dec_o.rd1.re = 1'b1;
					dec_o.wd = rt;
					dec_o.alusel = id_pkg::SEL_LOGIC;
					dec_o.imm = {16'h0, imm16};
					if (op == `ID_OP_ANDI) begin
						dec_o.aluop = id_pkg::ALU_AND;
					end else if (op == `ID_OP_XORI) begin
						dec_o.aluop = id_pkg::ALU_XOR;
					end else begin
						dec_o.aluop = id_pkg::ALU_OR;
					end
					// LUI is an OR with the shifted immediate
					if (op == `ID_OP_LUI) begin
						dec_o.imm = {imm16, 16'h0};
					end
				end
				`ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU, `ID_OP_LW, `ID_OP_LB: begin
					dec_o.wreg = 1'b1;
					dec_o.rd1.re = 1'b1;
					dec_o.wd = rt;
					dec_o.imm = {{16{imm16[15]}}, imm16};
					dec_o.alusel = id_pkg::SEL_ARITH;
					case (op)
						`ID_OP_ADDIU: dec_o.aluop = id_pkg::ALU_ADDU;
						`ID_OP_SLTI:  dec_o.aluop = id_pkg::ALU_SLT;
						`ID_OP_SLTIU: dec_o.aluop = id_pkg::ALU_SLTU;
						`ID_OP_LW: begin
							dec_o.aluop = id_pkg::ALU_LW;
							dec_o.alusel = id_pkg::SEL_LOAD_STORE;
						end
						default: begin
							dec_o.aluop = id_pkg::ALU_LB;
							dec_o.alusel = id_pkg::SEL_LOAD_STORE;
						end
					endcase
				end
				`ID_OP_SW: begin
					dec_o.aluop = id_pkg::ALU_SW;
					dec_o.alusel = id_pkg::SEL_LOAD_STORE;
					dec_o.rd1.re = 1'b1;
					dec_o.rd2.re = 1'b1;
					dec_o.wd = rt;
				end
				`ID_OP_BEQ, `ID_OP_BNE: begin
					dec_o.aluop = (op == `ID_OP_BEQ) ? id_pkg::ALU_BEQ : id_pkg::ALU_BNE;
					dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
					dec_o.rd1.re = 1'b1;
					dec_o.rd2.re = 1'b1;
				end
				`ID_OP_BGTZ, `ID_OP_BLEZ: begin
					dec_o.aluop = (op == `ID_OP_BGTZ) ? id_pkg::ALU_BGTZ : id_pkg::ALU_BLEZ;
					dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
					dec_o.rd1.re = 1'b1;
				end
				`ID_OP_J: begin
					dec_o.aluop = id_pkg::ALU_J;
					dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
				end
				`ID_OP_JAL: begin
					dec_o.aluop = id_pkg::ALU_JAL;
					dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
					dec_o.wreg = 1'b1;
					dec_o.wd = id_pkg::reg_addr_t'(`ID_LINK_REG);
					dec_o.link_en = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/id_ex_register.sv ====
`default_nettype none

module id_ex_register (
	input  logic           clk,
	input  logic           rst_i,
	input  logic           stall_i,
	input  id_pkg::dec_t   dec_i,
	input  id_pkg::word_t  reg1_i,
	input  id_pkg::word_t  reg2_i,
	input  id_pkg::word_t  link_addr_i,
	output id_pkg::id_ex_t ex_o
);

	always_ff @(posedge clk) begin
		if (rst_i || stall_i) begin
			// bubble so that EX writes nothing
			ex_o <= '0;
			ex_o.aluop <= id_pkg::ALU_NOP;
			ex_o.alusel <= id_pkg::SEL_NOP;
		end else begin
			ex_o.aluop <= dec_i.aluop;
			ex_o.alusel <= dec_i.alusel;
			ex_o.reg1 <= reg1_i;
			ex_o.reg2 <= reg2_i;
			ex_o.wd <= dec_i.wd;
			ex_o.wreg <= dec_i.wreg;
			ex_o.link_addr <= link_addr_i;
		end
	end

endmodule

`default_nettype wire

// ==== source/id_operand_fetch.sv ====
`default_nettype none

module id_operand_fetch (
	input  logic          rst_i,
	input  id_pkg::dec_t  dec_i,
	input  id_pkg::word_t reg1_data_i,
	input  id_pkg::word_t reg2_data_i,
	input  id_pkg::fwd_t  ex_fwd_i,
	input  id_pkg::fwd_t  mem_fwd_i,
	output id_pkg::word_t reg1_o,
	output id_pkg::word_t reg2_o,
	output logic          stall_o
);

	// EX result first, then MEM, then the register file
	function automatic id_pkg::word_t select_operand(
		input id_pkg::rf_read_t rd,
		input id_pkg::word_t    rf_data,
		input id_pkg::fwd_t     ex_fwd,
		input id_pkg::fwd_t     mem_fwd,
		input id_pkg::word_t    imm
	);
		id_pkg::word_t val;
		if (!rd.re) begin
			val = imm;
		end else if (ex_fwd.wreg && (ex_fwd.wd == rd.addr)) begin
			val = ex_fwd.wdata;
		end else if (mem_fwd.wreg && (mem_fwd.wd == rd.addr)) begin
			val = mem_fwd.wdata;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	logic ex_is_load;
	logic hit1;
	logic hit2;

	always_comb begin
		if (rst_i) begin
			reg1_o = '0;
			reg2_o = '0;
		end else begin
			reg1_o = select_operand(dec_i.rd1, reg1_data_i, ex_fwd_i, mem_fwd_i, dec_i.imm);
			reg2_o = select_operand(dec_i.rd2, reg2_data_i, ex_fwd_i, mem_fwd_i, dec_i.imm);
		end
	end

	//////////////////////////////
	// load-use hazard
	//////////////////////////////
	assign ex_is_load = (ex_fwd_i.aluop == id_pkg::ALU_LW) ||
			(ex_fwd_i.aluop == id_pkg::ALU_LB);
	assign hit1 = dec_i.rd1.re && (ex_fwd_i.wd == dec_i.rd1.addr);
	assign hit2 = dec_i.rd2.re && (ex_fwd_i.wd == dec_i.rd2.addr);

	assign stall_o = !rst_i && ex_is_load && (hit1 || hit2);

endmodule

`default_nettype wire

// ==== source/id_pkg.sv ====
`default_nettype none

`include "id_defs.svh"

package id_pkg;

	typedef logic [`ID_WORD_W-1:0]     word_t;
	typedef logic [`ID_WORD_W-1:0]     inst_addr_t;
	typedef logic [`ID_WORD_W-1:0]     inst_t;
	typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

	// detailed ALU operation with NOP at zero
	typedef enum logic [4:0] {
		ALU_NOP = 5'd0,
		ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_ADDU, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_LW, ALU_LB, ALU_SW,
		ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
		ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ
	} aluop_t;

	// result class
	typedef enum logic [2:0] {
		SEL_NOP = 3'd0,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_ARITH,
		SEL_LOAD_STORE,
		SEL_JUMP_BRANCH
	} alusel_t;

	typedef struct packed {
		logic      re;
		reg_addr_t addr;
	} rf_read_t;

	// result bypass from a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
		aluop_t    aluop;
	} fwd_t;

	typedef struct packed {
		aluop_t    aluop;
		alusel_t   alusel;
		rf_read_t  rd1;
		rf_read_t  rd2;
		reg_addr_t wd;
		logic      wreg;
		word_t     imm;
		logic      link_en;
	} dec_t;

	typedef struct packed {
		logic       taken;
		inst_addr_t target;
	} branch_t;

	typedef struct packed {
		aluop_t    aluop;
		alusel_t   alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
	} id_ex_t;

endpackage

`default_nettype wire

// ==== source/id_stage_top.sv ====
`default_nettype none

module id_stage_top (
	input  logic               clk,
	input  logic               rst_i,
	input  id_pkg::inst_addr_t pc_i,
	input  id_pkg::inst_t      inst_i,
	input  id_pkg::word_t      reg1_data_i,
	input  id_pkg::word_t      reg2_data_i,
	input  id_pkg::fwd_t       ex_fwd_i,
	input  id_pkg::fwd_t       mem_fwd_i,
	output id_pkg::rf_read_t   rd1_o,
	output id_pkg::rf_read_t   rd2_o,
	output id_pkg::branch_t    branch_o,
	output id_pkg::id_ex_t     ex_o,
	output logic               stall_o
);

	id_pkg::dec_t  dec;
	id_pkg::word_t reg1;
	id_pkg::word_t reg2;
	id_pkg::word_t link_addr;

	// register file read requests
	assign rd1_o = dec.rd1;
	assign rd2_o = dec.rd2;

	id_decoder id_decoder_i (
		.rst_i  (rst_i),
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	id_operand_fetch id_operand_fetch_i (
		.rst_i       (rst_i),
		.dec_i       (dec),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.reg1_o      (reg1),
		.reg2_o      (reg2),
		.stall_o     (stall_o)
	);

	id_branch_unit id_branch_unit_i (
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.dec_i       (dec),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.branch_o    (branch_o),
		.link_addr_o (link_addr)
	);

	id_ex_register id_ex_register_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.stall_i     (stall_o),
		.dec_i       (dec),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.link_addr_i (link_addr),
		.ex_o        (ex_o)
	);

endmodule

`default_nettype wire
